/* sources.f */
game_pkg.sv
network_pkg.sv
lane_tick_gen.sv
credit_counter.sv
packet_builder.sv
lane_serializer.sv
sender_top.sv
sender_checker.sv
tb_sender_top.sv

/* Bender.yml */
package:
  name: game_sender

sources:
  - game_pkg.sv
  - network_pkg.sv
  - lane_tick_gen.sv
  - credit_counter.sv
  - packet_builder.sv
  - lane_serializer.sv
  - sender_top.sv
  - target: test
    files:
      - sender_checker.sv
      - tb_sender_top.sv

/* tb_sender_top.sv */
// testbench for the network sender: random game traffic, a lane receiver model and checks.
`timescale 1ns/1ps

module tb_sender_top;

    import game_pkg::*;
    import network_pkg::*;

    localparam int CLK_DIV      = 4;
    localparam int INIT_CREDITS = 2;

    typedef struct packed {
        logic [GBG_BITS-1:0] garbage;
        tile_type_t          hold;
        piece_queue_t        queue;
        playfield_t          field;
    } game_state_t;

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic                              game_active;
    logic                              send_update;
    logic                              send_ready_ack;
    logic                              send_game_lost;
    logic [GBG_BITS-1:0]               garbage;
    tile_type_t                        hold;
    piece_queue_t                      piece_queue;
    playfield_t                        playfield;
    logic                              credit_return;
    logic                              lane_clk;
    logic                              lane_header;
    logic [NIBBLE_BITS-1:0]            lane_data;
    logic                              seq_num;
    logic [$clog2(INIT_CREDITS+1)-1:0] credits;
    logic                              send_done;

    integer      seed = 32'h0637_ff0d;
    logic [2:0]  pend;         // model pending flags, bit = kind code.
    logic [2:0]  req_q;
    logic        cr_q;
    logic        hdr_q;
    logic        lclk_q;
    logic        m_seq;
    int          m_cred;
    int          nib_cnt;
    int          done_cnt = 0;
    int          cycles;
    game_state_t in_q;         // inputs as the DUT saw them one cycle back.
    game_state_t snap;
    pkt_kind_t   snap_kind;
    pkt_kind_t   kind_log[$];  // kinds in start order.

    sender_top #(
        .CLK_DIV      (CLK_DIV),
        .INIT_CREDITS (INIT_CREDITS)
    ) sender_top_inst (.*);

    always #50 clk = ~clk;  // 100 ns period.

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("ERROR at %0t: timed out, %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic new_state();
        logic [$bits(playfield_t)-1:0] bits;
        logic [31:0]                   r;
        int                            i;
        for (i = 0; i < $bits(playfield_t) / 32; i++) begin
            bits[i*32 +: 32] = $random(seed);
        end
        r = $random(seed);
        playfield   <= playfield_t'(bits);
        piece_queue <= piece_queue_t'(r[23:0]);
        hold        <= tile_type_t'(r[27:24]);
        garbage     <= r[31:28];
    endtask

    task automatic step(input logic [2:0] req, input logic cr);
        @(posedge clk);
        new_state();
        {send_game_lost, send_ready_ack, send_update} <= req;
        credit_return <= cr;
    endtask

    task automatic rand_step();
        logic [31:0] r;
        r = $random(seed);
        game_active <= (r[31:30] != 2'b00);  // high three cycles in four.
        step({r[6:0] == 7'd0, r[13:7] == 7'd0, r[20:14] == 7'd0}, r[29:21] == 9'd0);
    endtask

    task automatic wait_done(input int n, input int limit);
        int cnt;
        cnt = 0;
        while (done_cnt < n) begin
            step(3'b000, 1'b0);
            cnt++;
            if (cnt > limit) begin
                fail_timeout("no packet finished");
            end
        end
    endtask

    function automatic pkt_kind_t pick_kind(input logic [2:0] p);
        if (p[pkt_game_lost]) return pkt_game_lost;
        if (p[pkt_ready_ack]) return pkt_ready_ack;
        return pkt_update;
    endfunction

    function automatic logic [NIBBLE_BITS-1:0] expected_nibble(input int idx);
        int t;
        t = idx - HDR_NIBBLES - NEXT_PIECES_COUNT;  // tile number in row-major order.
        if (idx == 0) return {snap_kind, m_seq, 1'b0};
        if (idx == 1) return snap.garbage;
        if (idx == 2) return snap.hold;
        if (t < 0) return snap.queue[idx - HDR_NIBBLES];
        if (t < PLAYFIELD_TILES) return snap.field[t / PLAYFIELD_COLS][t % PLAYFIELD_COLS];
        return '0;
    endfunction

    // receiver model on the falling edge, where all DUT outputs are settled.
    always @(negedge clk) begin : model
        logic start;
        start = lane_header && !hdr_q;
        if (!arst_n) begin
            pend   = '0;
            m_cred = INIT_CREDITS;
            m_seq  = 1'b0;
        end else begin
            if (start) begin
                check_value(pend != 3'b000, 1, "packet started with no request pending");
                check_value(seq_num, m_seq, "seq_num at packet start");
                snap_kind       = pick_kind(pend);
                snap            = in_q;
                pend[snap_kind] = 1'b0;
                nib_cnt         = 0;
                kind_log.push_back(snap_kind);
            end
            if (start && !cr_q) begin
                m_cred--;
            end else if (cr_q && !start && m_cred < INIT_CREDITS) begin
                m_cred++;  // returns beyond the initial count are dropped.
            end
            pend = pend | req_q;
            check_value(credits, m_cred, "credit count");
            if (lane_clk && !lclk_q && lane_header) begin
                check_value(lane_data, expected_nibble(nib_cnt), "lane nibble");
                nib_cnt++;
            end
            if (!lane_header && hdr_q) begin
                check_value(nib_cnt, PACKET_NIBBLES, "nibbles in packet");
                check_value(send_done, 1, "send_done when lane_header falls");
                done_cnt++;
                m_seq = ~m_seq;
            end
        end
        req_q  = {send_game_lost, send_ready_ack, send_update} & {3{game_active}};
        cr_q   = credit_return;
        in_q   = {garbage, hold, piece_queue, playfield};
        hdr_q  = lane_header;
        lclk_q = lane_clk;
    end

    initial begin
        arst_n         = 1'b0;
        game_active    = 1'b0;
        send_update    = 1'b0;
        send_ready_ack = 1'b0;
        send_game_lost = 1'b0;
        credit_return  = 1'b0;
        new_state();
        repeat (16) step(3'b000, 1'b0);
        arst_n <= 1'b1;
        step(3'b000, 1'b0);
        check_value(lane_header, 0, "lane_header after reset");
        check_value(send_done, 0, "send_done after reset");
        check_value(seq_num, 0, "seq_num after reset");
        check_value(credits, INIT_CREDITS, "credits after reset");
        repeat (2) step(3'b111, 1'b0);  // game inactive, so dropped.
        repeat (40) step(3'b000, 1'b0);
        check_value(kind_log.size(), 0, "packets while game inactive");
        game_active <= 1'b1;
        step(3'b111, 1'b0);
        repeat (2) step(3'b001, 1'b0);
        wait_done(2, 4000);
        repeat (50) step(3'b000, 1'b0);
        check_value(kind_log.size(), 2, "packets started without credit");
        check_value(credits, 0, "credits after two packets");
        check_value(kind_log[0], pkt_game_lost, "first packet kind");
        check_value(kind_log[1], pkt_ready_ack, "second packet kind");
        step(3'b000, 1'b1);
        wait_done(3, 4000);
        step(3'b000, 1'b1);  // a spare credit lets a duplicate update show.
        repeat (50) step(3'b000, 1'b0);
        check_value(kind_log.size(), 3, "packets for merged update pulses");
        check_value(kind_log[2], pkt_update, "third packet kind");
        repeat (20000) rand_step();
        check_value(done_cnt > 6, 1, "enough packets in random run");
        game_active <= 1'b1;
        cycles = 0;
        do begin
            step(3'b000, (cycles % 64) == 0);  // keep credits flowing back.
            cycles++;
            if (cycles > 20000) begin
                fail_timeout("pending requests were never sent");
            end
        end while ((pend | req_q) != 3'b000 || lane_header || done_cnt != kind_log.size());
        repeat (2 * CLK_DIV) step(3'b000, 1'b1);  // no packet may follow once drained.
        check_value(lane_header, 0, "lane_header after drain");
        check_value(kind_log.size(), done_cnt, "packets started after drain");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* sender_checker.sv */
// lane protocol checker: assertions on lane framing, send_done timing and credits.
`timescale 1ns/1ps

module sender_checker #(
    parameter int INIT_CREDITS = 2
) (
    input logic                                clk,
    input logic                                arst_n,
    input logic                                lane_clk,
    input logic                                lane_header,
    input logic [network_pkg::NIBBLE_BITS-1:0] lane_data,
    input logic [$clog2(INIT_CREDITS+1)-1:0]   credits,
    input logic                                send_done
);

    // lanes only move on the tick edge, where lane_clk falls.
    assert property (@(posedge clk) disable iff (!arst_n)
        lane_clk && $past(lane_clk) |-> $stable(lane_data) && $stable(lane_header))
        else $error("lane data or header changed while lane_clk was high");

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(lane_header) |-> $past(credits) != '0)
        else $error("lane_header rose with no credit left");

    assert property (@(posedge clk) disable iff (!arst_n)
        send_done == $fell(lane_header))
        else $error("send_done out of step with lane_header falling");

    assert property (@(posedge clk) disable iff (!arst_n)
        credits <= INIT_CREDITS)
        else $error("credit count above its initial value");

endmodule

bind sender_top sender_checker #(.INIT_CREDITS(INIT_CREDITS)) sender_checker_inst (.*);

/* sender_top.sv */
// sender top: network sender that frames game snapshots onto credit-controlled nibble lanes.
`timescale 1ns/1ps

module sender_top #(
    parameter int CLK_DIV      = 500,
    parameter int INIT_CREDITS = 2
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                game_active,
    input  logic                                send_update,
    input  logic                                send_ready_ack,
    input  logic                                send_game_lost,
    input  logic [game_pkg::GBG_BITS-1:0]       garbage,
    input  game_pkg::tile_type_t                hold,
    input  game_pkg::piece_queue_t              piece_queue,
    input  game_pkg::playfield_t                playfield,
    input  logic                                credit_return,
    output logic                                lane_clk,
    output logic                                lane_header,
    output logic [network_pkg::NIBBLE_BITS-1:0] lane_data,
    output logic                                seq_num,
    output logic [$clog2(INIT_CREDITS+1)-1:0]   credits,
    output logic                                send_done
);

    import network_pkg::*;

    logic                   tick;
    logic                   has_credit;
    logic                   pkt_valid;
    logic                   pkt_start;
    logic                   pkt_end;
    logic [NIBBLE_BITS-1:0] nibble;
    nibble_idx_t            nib_idx;

    lane_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) lane_tick_gen_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .lane_clk (lane_clk)
    );

    credit_counter #(
        .INIT_CREDITS (INIT_CREDITS)
    ) credit_counter_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .pkt_start     (pkt_start),
        .credit_return (credit_return),
        .credits       (credits),
        .has_credit    (has_credit)
    );

    packet_builder packet_builder_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .game_active    (game_active),
        .send_update    (send_update),
        .send_ready_ack (send_ready_ack),
        .send_game_lost (send_game_lost),
        .garbage        (garbage),
        .hold           (hold),
        .piece_queue    (piece_queue),
        .playfield      (playfield),
        .pkt_start      (pkt_start),
        .pkt_end        (pkt_end),
        .nib_idx        (nib_idx),
        .pkt_valid      (pkt_valid),
        .nibble         (nibble),
        .seq_num        (seq_num)
    );

    lane_serializer lane_serializer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .tick        (tick),
        .pkt_valid   (pkt_valid),
        .has_credit  (has_credit),
        .nibble      (nibble),
        .pkt_start   (pkt_start),
        .pkt_end     (pkt_end),
        .nib_idx     (nib_idx),
        .lane_header (lane_header),
        .lane_data   (lane_data),
        .send_done   (send_done)
    );

endmodule

/* lane_serializer.sv */
// lane serializer: shifts a packet out one nibble per lane tick with a framing header lane.
`timescale 1ns/1ps

module lane_serializer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                tick,
    input  logic                                pkt_valid,
    input  logic                                has_credit,
    input  logic [network_pkg::NIBBLE_BITS-1:0] nibble,
    output logic                                pkt_start,
    output logic                                pkt_end,
    output network_pkg::nibble_idx_t            nib_idx,
    output logic                                lane_header,
    output logic [network_pkg::NIBBLE_BITS-1:0] lane_data,
    output logic                                send_done
);

    import network_pkg::*;

    typedef enum logic {
        st_idle,
        st_send
    } state_t;

    state_t state;
    logic   last_nib;

    // a start only lands on a tick, so the first nibble gets a full period.
    assign pkt_start = tick && (state == st_idle) && pkt_valid && has_credit;
    assign last_nib  = (nib_idx == nibble_idx_t'(PACKET_NIBBLES));  // all nibbles shown.
    assign send_done = pkt_end;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            nib_idx     <= '0;
            lane_header <= 1'b0;
            lane_data   <= '0;
            pkt_end     <= 1'b0;
        end else begin
            pkt_end <= 1'b0;
            if (tick) begin
                case (state)
                    st_idle: begin
                        if (pkt_start) begin
                            state       <= st_send;
                            lane_header <= 1'b1;  // header rises with nibble 0.
                            lane_data   <= nibble;
                            nib_idx     <= nib_idx + 1'b1;
                        end
                    end
                    st_send: begin
                        if (last_nib) begin
                            state       <= st_idle;
                            lane_header <= 1'b0;
                            lane_data   <= '0;
                            nib_idx     <= '0;
                            pkt_end     <= 1'b1;  // high while header is first low.
                        end else begin
                            lane_data <= nibble;
                            nib_idx   <= nib_idx + 1'b1;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

/* packet_builder.sv */
// packet builder: merges send requests, picks the next packet and serves snapshot nibbles.
`timescale 1ns/1ps

module packet_builder (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              game_active,
    input  logic                              send_update,
    input  logic                              send_ready_ack,
    input  logic                              send_game_lost,
    input  logic [game_pkg::GBG_BITS-1:0]     garbage,
    input  game_pkg::tile_type_t              hold,
    input  game_pkg::piece_queue_t            piece_queue,
    input  game_pkg::playfield_t              playfield,
    input  logic                              pkt_start,
    input  logic                              pkt_end,
    input  network_pkg::nibble_idx_t          nib_idx,
    output logic                              pkt_valid,
    output logic [network_pkg::NIBBLE_BITS-1:0] nibble,
    output logic                              seq_num
);

    import game_pkg::*;
    import network_pkg::*;

    logic [NUM_KINDS-1:0] pending;  // one flag per kind, bit = kind code.
    logic [NUM_KINDS-1:0] req;
    logic [NUM_KINDS-1:0] clr;
    pkt_kind_t            sel_kind;

    logic [GBG_BITS-1:0]     garbage_q;
    tile_type_t              hold_q;
    piece_queue_t            queue_q;
    playfield_t              field_q;
    logic [PLAYFIELD_TILES*TILE_BITS-1:0] field_flat;

    assign req = {send_game_lost, send_ready_ack, send_update} & {NUM_KINDS{game_active}};

    // game_lost wins over ready_ack, which wins over update.
    always_comb begin
        if (pending[pkt_game_lost]) begin
            sel_kind = pkt_game_lost;
        end else if (pending[pkt_ready_ack]) begin
            sel_kind = pkt_ready_ack;
        end else begin
            sel_kind = pkt_update;
        end
    end

    assign pkt_valid = |pending;
    assign clr       = pkt_start ? (NUM_KINDS'(1) << sel_kind) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
            seq_num <= 1'b0;
        end else begin
            pending <= (pending & ~clr) | req;  // a pulse in the start cycle stays pending.
            if (pkt_end) begin
                seq_num <= ~seq_num;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            garbage_q <= garbage;
            hold_q    <= hold;
            queue_q   <= piece_queue;
            field_q   <= playfield;
        end
    end

    assign field_flat = field_q;  // tile r*COLS+c sits at slice r*COLS+c.

    // header nibble is read in the start cycle, before the snapshot lands.
    always_comb begin
        int idx;
        idx = int'(nib_idx);
        if (idx == NIB_HEADER) begin
            nibble = {sel_kind, seq_num, 1'b0};
        end else if (idx == NIB_GARBAGE) begin
            nibble = NIBBLE_BITS'(garbage_q);
        end else if (idx == NIB_HOLD) begin
            nibble = hold_q;
        end else if (idx < FIELD_BASE) begin
            nibble = queue_q[idx - QUEUE_BASE];
        end else if (idx < PACKET_NIBBLES) begin
            nibble = field_flat[(idx - FIELD_BASE) * TILE_BITS +: TILE_BITS];
        end else begin
            nibble = '0;
        end
    end

endmodule

/* credit_counter.sv */
// credit counter: tracks free receive buffers at the far end and gates packet starts.
`timescale 1ns/1ps

module credit_counter #(
    parameter int INIT_CREDITS = 2
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                pkt_start,
    input  logic                                credit_return,
    output logic [$clog2(INIT_CREDITS+1)-1:0]   credits,
    output logic                                has_credit
);

    localparam int CREDIT_W = $clog2(INIT_CREDITS + 1);

    logic [CREDIT_W-1:0] credits_nxt;

    always_comb begin
        credits_nxt = credits;
        if (pkt_start && !credit_return) begin
            credits_nxt = credits - 1'b1;  // serializer only starts with credit.
        end else if (credit_return && !pkt_start) begin
            if (credits != CREDIT_W'(INIT_CREDITS)) begin
                credits_nxt = credits + 1'b1;  // extra returns are dropped.
            end
        end
    end

    // has_credit is registered from the same next value as the count.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits    <= CREDIT_W'(INIT_CREDITS);
            has_credit <= (INIT_CREDITS != 0);
        end else begin
            credits    <= credits_nxt;
            has_credit <= (credits_nxt != '0);
        end
    end

endmodule

/* lane_tick_gen.sv */
// lane tick generator: divides clk into a one-cycle lane tick and the lane clock phase.
`timescale 1ns/1ps

module lane_tick_gen #(
    parameter int CLK_DIV = 500
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick,
    output logic lane_clk
);

    localparam int HALF  = CLK_DIV / 2;
    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_nxt;

    assign tick = (cnt == CNT_W'(CLK_DIV - 1));  // last cycle of each lane period.

    always_comb begin
        cnt_nxt = tick ? '0 : cnt + 1'b1;  // modulo CLK_DIV.
    end

    // lane_clk follows the count, so it is low for HALF cycles after a tick.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            lane_clk <= 1'b0;
        end else begin
            cnt      <= cnt_nxt;
            lane_clk <= (cnt_nxt >= CNT_W'(HALF));  // rises mid period.
        end
    end

endmodule

/* network_pkg.sv */
// network package: packet kinds, nibble layout and packet length of the lane protocol.
package network_pkg;

    import game_pkg::*;

    // the kind code doubles as the bit position of its pending flag.
    typedef enum logic [1:0] {
        pkt_update    = 2'd0,
        pkt_ready_ack = 2'd1,
        pkt_game_lost = 2'd2
    } pkt_kind_t;

    localparam int NUM_KINDS   = 3;  // number of packet kinds.
    localparam int NIBBLE_BITS = 4;  // one bit per data lane.

    // header nibbles.
    //   0: kind in 3:2, sequence number in 1, zero in 0.
    //   1: garbage line count.
    //   2: hold piece.
    localparam int HDR_NIBBLES = 3;
    localparam int NIB_HEADER  = 0;
    localparam int NIB_GARBAGE = 1;
    localparam int NIB_HOLD    = 2;

    // body follows the header: queue entries, then tiles row by row.
    localparam int QUEUE_BASE = HDR_NIBBLES;
    localparam int FIELD_BASE = QUEUE_BASE + NEXT_PIECES_COUNT;

    localparam int PACKET_NIBBLES = HDR_NIBBLES + NEXT_PIECES_COUNT + PLAYFIELD_TILES;

    localparam int NIB_IDX_BITS = $clog2(PACKET_NIBBLES + 1);

    typedef logic [NIB_IDX_BITS-1:0] nibble_idx_t;  // counts up to PACKET_NIBBLES.

endpackage

/* game_pkg.sv */
// game state package: tile kinds, piece queue and playfield types with their sizes.
package game_pkg;

    localparam int PLAYFIELD_ROWS    = 20;  // rows in the playfield.
    localparam int PLAYFIELD_COLS    = 10;  // columns in the playfield.
    localparam int NEXT_PIECES_COUNT = 6;   // depth of the next-piece queue.
    localparam int GBG_BITS          = 4;   // width of the garbage-line count.
    localparam int TILE_BITS         = 4;   // width of one tile code.

    // tile or piece kind; blank marks an empty cell or no hold piece.
    typedef enum logic [TILE_BITS-1:0] {
        tile_blank   = 4'd0,
        tile_i       = 4'd1,
        tile_o       = 4'd2,
        tile_t       = 4'd3,
        tile_l       = 4'd4,
        tile_j       = 4'd5,
        tile_s       = 4'd6,
        tile_z       = 4'd7,
        tile_garbage = 4'd8
    } tile_type_t;

    // entry 0 is the next piece to fall.
    typedef tile_type_t [NEXT_PIECES_COUNT-1:0] piece_queue_t;

    // indexed [row][col]; row 0 col 0 sits at the low end of the vector.
    typedef tile_type_t [PLAYFIELD_ROWS-1:0][PLAYFIELD_COLS-1:0] playfield_t;

    localparam int PLAYFIELD_TILES = PLAYFIELD_ROWS * PLAYFIELD_COLS;

endpackage
